/* Makefile */
# Verilator build and run of the biquad filter testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module biquad_tb \
		-Mdir obj_dir -o biquad_sim

# the result is taken from the log
run: compile
	./obj_dir/biquad_sim > sim.log 2>&1; cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* design/biquad_filter_top.sv */
`timescale 1ns/10ps

module biquad_filter_top #(
    parameter int NSAMP = 8
) (
    input  logic                                        wb_clk_i,
    input  logic                                        clk_i,
    input  logic                                        arst_n_i,
    input  biquad_pkg::wb_req_t                         wb_req_i,
    input  logic                                        global_update_i,
    input  logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0]  dat_i,
    output logic                                        wb_ack_o,
    output logic [biquad_pkg::WB_DAT_W-1:0]             wb_dat_o,
    output logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0]  dat_o
);

    biquad_pkg::coeff_wr_t                      coeff_wr;
    logic                                       update;
    logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0] fir_dat;

    biquad_wb_regs u_regs (
        .wb_clk_i        (wb_clk_i),
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .wb_req_i        (wb_req_i),
        .global_update_i (global_update_i),
        .wb_ack_o        (wb_ack_o),
        .wb_dat_o        (wb_dat_o),
        .coeff_wr_o      (coeff_wr),
        .update_o        (update)
    );

    // zeros first, then poles
    biquad_zero_fir #(
        .NSAMP (NSAMP)
    ) u_zero_fir (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .dat_i      (dat_i),
        .coeff_wr_i (coeff_wr),
        .update_i   (update),
        .dat_o      (fir_dat)
    );

    biquad_pole_iir #(
        .NSAMP (NSAMP)
    ) u_pole_iir (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .dat_i      (fir_dat),
        .coeff_wr_i (coeff_wr),
        .update_i   (update),
        .dat_o      (dat_o)
    );

endmodule

/* design/biquad_pkg.sv */
package biquad_pkg;

    // sample and coefficient formats
    localparam int SAMPLE_W   = 16;
    localparam int COEFF_W    = 18;
    localparam int COEFF_FRAC = 14;
    localparam logic signed [COEFF_W-1:0] COEFF_ONE = 18'sd16384;

    // width of the intermediate product sums, wide enough for three taps
    localparam int SUM_W = 40;
    localparam logic signed [SUM_W-1:0] SAT_MAX = (2 ** (SAMPLE_W - 1)) - 1;
    localparam logic signed [SUM_W-1:0] SAT_MIN = -(2 ** (SAMPLE_W - 1));

    // register port
    localparam int WB_ADR_W = 7;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = WB_DAT_W / 8;

    // coefficient targets, encoded by their byte address
    // control register sits at 0x00
    typedef enum logic [WB_ADR_W-1:0] {
        SEL_B0 = 7'h04,
        SEL_B1 = 7'h08,
        SEL_B2 = 7'h0C,
        SEL_A1 = 7'h10,
        SEL_A2 = 7'h14
    } coeff_sel_e;

    typedef struct packed {
        logic                      valid;
        coeff_sel_e                sel;
        logic signed [COEFF_W-1:0] value;
    } coeff_wr_t;

    typedef struct packed {
        logic [WB_DAT_W-COEFF_W-1:0] rsvd;
        logic signed [COEFF_W-1:0]   value;
    } wb_coeff_view_t;

    typedef struct packed {
        logic [WB_DAT_W-2:0] rsvd;
        logic                update;
    } wb_ctrl_view_t;

    // one written word, read as coefficient or control depending on address
    typedef union packed {
        wb_coeff_view_t coeff;
        wb_ctrl_view_t  ctrl;
    } wb_wdata_u;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_SEL_W-1:0] sel;
        wb_wdata_u           dat;
    } wb_req_t;

    // clamp a wide signed sum into one sample
    function automatic logic signed [SAMPLE_W-1:0] sat_sample(
        input logic signed [SUM_W-1:0] x
    );
        if (x > SAT_MAX) begin
            return SAT_MAX[SAMPLE_W-1:0];
        end
        if (x < SAT_MIN) begin
            return SAT_MIN[SAMPLE_W-1:0];
        end
        return x[SAMPLE_W-1:0];
    endfunction

endpackage

/* design/biquad_pole_iir.sv */
`timescale 1ns/10ps

module biquad_pole_iir #(
    parameter int NSAMP = 8
) (
    input  logic                                        clk_i,
    input  logic                                        arst_n_i,
    input  logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0]  dat_i,
    input  biquad_pkg::coeff_wr_t                       coeff_wr_i,
    input  logic                                        update_i,
    output logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0]  dat_o
);

    logic signed [biquad_pkg::COEFF_W-1:0] a1_stg_q;
    logic signed [biquad_pkg::COEFF_W-1:0] a2_stg_q;
    logic signed [biquad_pkg::COEFF_W-1:0] a1_act_q;
    logic signed [biquad_pkg::COEFF_W-1:0] a2_act_q;

    // y[n-1] and y[n-2] carried over from the previous frame
    logic signed [biquad_pkg::SAMPLE_W-1:0] y1_q;
    logic signed [biquad_pkg::SAMPLE_W-1:0] y2_q;

    // saturated outputs, two state entries first then one per lane
    logic signed [biquad_pkg::SAMPLE_W-1:0] ychain [NSAMP+2];
    logic signed [biquad_pkg::SUM_W-1:0]    fb_sum [NSAMP];
    logic signed [biquad_pkg::SUM_W-1:0]    lane_sum [NSAMP];
    logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0] iir_next;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a1_stg_q <= '0;
            a2_stg_q <= '0;
            a1_act_q <= '0;
            a2_act_q <= '0;
        end else begin
            if (coeff_wr_i.valid) begin
                case (coeff_wr_i.sel)
                    biquad_pkg::SEL_A1: a1_stg_q <= coeff_wr_i.value;
                    biquad_pkg::SEL_A2: a2_stg_q <= coeff_wr_i.value;
                    default: ;
                endcase
            end
            if (update_i) begin
                a1_act_q <= a1_stg_q;
                a2_act_q <= a2_stg_q;
            end
        end
    end

    // recursion runs through all lanes in one cycle
    // each lane feeds back the saturated value of the lane before it
    always_comb begin
        ychain[0] = y2_q;
        ychain[1] = y1_q;
        for (int k = 0; k < NSAMP; k++) begin
            fb_sum[k] = a1_act_q * ychain[k+1] + a2_act_q * ychain[k];
            lane_sum[k] = biquad_pkg::SUM_W'($signed(dat_i[k]))
                        + (fb_sum[k] >>> biquad_pkg::COEFF_FRAC);
            ychain[k+2] = biquad_pkg::sat_sample(lane_sum[k]);
        end
        for (int k = 0; k < NSAMP; k++) begin
            iir_next[k] = ychain[k+2];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            y1_q  <= '0;
            y2_q  <= '0;
            dat_o <= '0;
        end else begin
            y1_q  <= ychain[NSAMP+1];
            y2_q  <= ychain[NSAMP];
            dat_o <= iir_next;
        end
    end

endmodule

/* design/biquad_wb_regs.sv */
`timescale 1ns/10ps

module biquad_wb_regs (
    input  logic                            wb_clk_i,
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  biquad_pkg::wb_req_t             wb_req_i,
    input  logic                            global_update_i,
    output logic                            wb_ack_o,
    output logic [biquad_pkg::WB_DAT_W-1:0] wb_dat_o,
    output biquad_pkg::coeff_wr_t           coeff_wr_o,
    output logic                            update_o
);

    logic wr_req;
    logic rd_req;
    logic pending_q;
    logic pending_dly_q;
    logic read_ack_q;
    logic update_wb_q;
    logic wr_launch;

    // captured write stays stable while pending
    logic [biquad_pkg::WB_ADR_W-1:0] hold_adr_q;
    logic [biquad_pkg::WB_SEL_W-1:0] hold_sel_q;
    biquad_pkg::wb_wdata_u           hold_dat_q;

    logic [biquad_pkg::WB_ADR_W-1:0] word_adr;
    biquad_pkg::coeff_sel_e          coeff_sel;
    logic                            coeff_hit;
    logic                            ctrl_upd;

    logic                  wr_clk;
    logic                  ack_wb;
    logic                  update_clk;
    biquad_pkg::coeff_wr_t coeff_wr_q;
    logic                  update_q;

    assign wr_req = wb_req_i.cyc && wb_req_i.stb && wb_req_i.we;
    assign rd_req = wb_req_i.cyc && wb_req_i.stb && !wb_req_i.we;

    // one pulse on the first cycle a write is pending
    assign wr_launch = pending_q && !pending_dly_q;

    // address decode on the held word ignores the low two bits
    always_comb begin
        word_adr  = {hold_adr_q[biquad_pkg::WB_ADR_W-1:2], 2'b00};
        coeff_sel = biquad_pkg::coeff_sel_e'(word_adr);
        ctrl_upd  = (word_adr == '0) && hold_sel_q[0] && hold_dat_q.ctrl.update;
        case (word_adr)
            biquad_pkg::SEL_B0, biquad_pkg::SEL_B1, biquad_pkg::SEL_B2,
            biquad_pkg::SEL_A1, biquad_pkg::SEL_A2: begin
                coeff_hit = 1'b1;
            end
            default: begin
                coeff_hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q     <= 1'b0;
            pending_dly_q <= 1'b0;
            read_ack_q    <= 1'b0;
            update_wb_q   <= 1'b0;
        end else begin
            if (ack_wb) begin
                pending_q <= 1'b0;
            end else if (wr_req && !pending_q) begin
                pending_q <= 1'b1;
            end
            pending_dly_q <= pending_q;
            // reads ack on the next edge and never twice in a row
            read_ack_q    <= rd_req && !read_ack_q;
            // control update and global update share one crossing
            update_wb_q   <= global_update_i || (wr_launch && ctrl_upd);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wr_req && !pending_q) begin
            hold_adr_q <= wb_req_i.adr;
            hold_sel_q <= wb_req_i.sel;
            hold_dat_q <= wb_req_i.dat;
        end
    end

    flag_sync u_wr_sync (
        .src_clk_i (wb_clk_i),
        .dst_clk_i (clk_i),
        .arst_n_i  (arst_n_i),
        .flag_i    (wr_launch),
        .flag_o    (wr_clk)
    );

    // the arriving write pulse goes straight back as the acknowledge
    flag_sync u_ack_sync (
        .src_clk_i (clk_i),
        .dst_clk_i (wb_clk_i),
        .arst_n_i  (arst_n_i),
        .flag_i    (wr_clk),
        .flag_o    (ack_wb)
    );

    flag_sync u_update_sync (
        .src_clk_i (wb_clk_i),
        .dst_clk_i (clk_i),
        .arst_n_i  (arst_n_i),
        .flag_i    (update_wb_q),
        .flag_o    (update_clk)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            coeff_wr_q <= '0;
            update_q   <= 1'b0;
        end else begin
            coeff_wr_q.valid <= wr_clk && coeff_hit;
            if (wr_clk) begin
                coeff_wr_q.sel   <= coeff_sel;
                coeff_wr_q.value <= hold_dat_q.coeff.value;
            end
            update_q <= update_clk;
        end
    end

    assign coeff_wr_o = coeff_wr_q;
    assign update_o   = update_q;

    assign wb_ack_o = (ack_wb && pending_q) || read_ack_q;
    // no readback
    assign wb_dat_o = '0;

endmodule

/* design/biquad_zero_fir.sv */
`timescale 1ns/10ps

module biquad_zero_fir #(
    parameter int NSAMP = 8
) (
    input  logic                                        clk_i,
    input  logic                                        arst_n_i,
    input  logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0]  dat_i,
    input  biquad_pkg::coeff_wr_t                       coeff_wr_i,
    input  logic                                        update_i,
    output logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0]  dat_o
);

    // index 0 is b0, 1 is b1, 2 is b2
    logic signed [biquad_pkg::COEFF_W-1:0] b_stg_q [3];
    logic signed [biquad_pkg::COEFF_W-1:0] b_act_q [3];

    // last two samples of the previous frame, [1] is the newest
    logic signed [biquad_pkg::SAMPLE_W-1:0] hist_q [2];

    // history followed by the current frame, oldest first
    logic signed [biquad_pkg::SAMPLE_W-1:0] ext [NSAMP+2];
    logic signed [biquad_pkg::SUM_W-1:0]    tap_sum [NSAMP];
    logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0] fir_next;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            b_stg_q[0] <= biquad_pkg::COEFF_ONE;
            b_stg_q[1] <= '0;
            b_stg_q[2] <= '0;
            b_act_q[0] <= biquad_pkg::COEFF_ONE;
            b_act_q[1] <= '0;
            b_act_q[2] <= '0;
        end else begin
            if (coeff_wr_i.valid) begin
                case (coeff_wr_i.sel)
                    biquad_pkg::SEL_B0: b_stg_q[0] <= coeff_wr_i.value;
                    biquad_pkg::SEL_B1: b_stg_q[1] <= coeff_wr_i.value;
                    biquad_pkg::SEL_B2: b_stg_q[2] <= coeff_wr_i.value;
                    default: ;
                endcase
            end
            // staged set goes live all at once
            if (update_i) begin
                b_act_q <= b_stg_q;
            end
        end
    end

    always_comb begin
        ext[0] = hist_q[0];
        ext[1] = hist_q[1];
        for (int k = 0; k < NSAMP; k++) begin
            ext[k+2] = $signed(dat_i[k]);
        end
        for (int k = 0; k < NSAMP; k++) begin
            tap_sum[k] = b_act_q[0] * ext[k+2]
                       + b_act_q[1] * ext[k+1]
                       + b_act_q[2] * ext[k];
            fir_next[k] = biquad_pkg::sat_sample(tap_sum[k] >>> biquad_pkg::COEFF_FRAC);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_q[0] <= '0;
            hist_q[1] <= '0;
            dat_o     <= '0;
        end else begin
            hist_q[0] <= $signed(dat_i[NSAMP-2]);
            hist_q[1] <= $signed(dat_i[NSAMP-1]);
            dat_o     <= fir_next;
        end
    end

endmodule

/* design/flag_sync.sv */
`timescale 1ns/10ps

module flag_sync (
    input  logic src_clk_i,
    input  logic dst_clk_i,
    input  logic arst_n_i,
    input  logic flag_i,
    output logic flag_o
);

    logic       src_tgl_q;
    logic [2:0] dst_sync_q;

    // each source flag flips the level seen by the other side
    always_ff @(posedge src_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            src_tgl_q <= 1'b0;
        end else if (flag_i) begin
            src_tgl_q <= ~src_tgl_q;
        end
    end

    // two synchronizer stages, the third one only for edge detection
    always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dst_sync_q <= '0;
        end else begin
            dst_sync_q <= {dst_sync_q[1:0], src_tgl_q};
        end
    end

    assign flag_o = dst_sync_q[2] ^ dst_sync_q[1];

endmodule

/* sim.f */
design/biquad_pkg.sv
design/flag_sync.sv
design/biquad_wb_regs.sv
design/biquad_zero_fir.sv
design/biquad_pole_iir.sv
design/biquad_filter_top.sv
tests/biquad_properties.sv
tests/biquad_tb.sv

/* tests/biquad_properties.sv */
`timescale 1ns/10ps

module biquad_properties (
    input logic                  wb_clk_i,
    input logic                  clk_i,
    input logic                  arst_n_i,
    input biquad_pkg::wb_req_t   wb_req_i,
    input logic                  wb_ack_i,
    input biquad_pkg::coeff_wr_t coeff_wr_i,
    input logic                  update_i
);

    // ack only inside an active bus cycle
    ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        wb_ack_i |-> (wb_req_i.cyc && wb_req_i.stb))
        else $error("wb_ack_o without cyc and stb");

    // every coefficient write is a single-cycle strobe
    single_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        coeff_wr_i.valid |=> !coeff_wr_i.valid)
        else $error("coeff_wr_o valid high on two cycles in a row");

    ack_reset: assert property (@(posedge wb_clk_i) !arst_n_i |-> !wb_ack_i)
        else $error("wb_ack_o high during reset");

    strobe_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> !(coeff_wr_i.valid || update_i))
        else $error("coefficient write or update during reset");

endmodule

bind biquad_wb_regs biquad_properties u_properties (
    .wb_clk_i   (wb_clk_i),
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wb_req_i   (wb_req_i),
    .wb_ack_i   (wb_ack_o),
    .coeff_wr_i (coeff_wr_o),
    .update_i   (update_o)
);

/* tests/biquad_tb.sv */
`timescale 1ns/10ps

module biquad_tb;

    localparam int NSAMP = 8;
    localparam int QUIET_CYCLES = 12;

    typedef logic [NSAMP-1:0][biquad_pkg::SAMPLE_W-1:0] frame_t;

    logic                clk_i = 1'b0;
    logic                wb_clk_i = 1'b0;
    logic                arst_n_i;
    biquad_pkg::wb_req_t wb_req;
    logic                global_update;
    frame_t              dat_in;
    frame_t              dat_out;
    logic                wb_ack;
    logic [31:0]         wb_rdata;

    // reference model state with staging and active coefficients
    longint stg_b [3];
    longint act_b [3];
    longint stg_a [2];
    longint act_a [2];
    longint fir_hist [2];
    longint iir_y1;
    longint iir_y2;

    frame_t stim_q [$];
    frame_t exp_q [$];
    int     errors = 0;
    int     checks = 0;
    int     tests_done = 0;
    int     test_err_base = 0;
    bit     running = 1'b0;
    int     seed = 32'h27fe;

    always #5 clk_i = ~clk_i;
    always #7 wb_clk_i = ~wb_clk_i;

    biquad_filter_top #(
        .NSAMP (NSAMP)
    ) UUT (
        .wb_clk_i        (wb_clk_i),
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .wb_req_i        (wb_req),
        .global_update_i (global_update),
        .dat_i           (dat_in),
        .wb_ack_o        (wb_ack),
        .wb_dat_o        (wb_rdata),
        .dat_o           (dat_out)
    );

    function automatic longint clamp_sample(input longint v);
        if (v > 32767) begin
            return 32767;
        end
        if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    function automatic logic [31:0] coeff_word(input int v);
        return {14'b0, v[17:0]};
    endfunction

    task automatic check_value(input string what, input logic [NSAMP*16-1:0] got,
                               input logic [NSAMP*16-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // zeros then poles for one sample at a time in lane order
    task automatic model_frame(input frame_t x, output frame_t y);
        longint xs [NSAMP+2];
        longint ys [NSAMP+2];
        longint w;
        xs[0] = fir_hist[0];
        xs[1] = fir_hist[1];
        ys[0] = iir_y2;
        ys[1] = iir_y1;
        for (int k = 0; k < NSAMP; k++) begin
            xs[k+2] = longint'($signed(x[k]));
        end
        for (int k = 0; k < NSAMP; k++) begin
            w = clamp_sample((act_b[0] * xs[k+2] + act_b[1] * xs[k+1] + act_b[2] * xs[k])
                             >>> biquad_pkg::COEFF_FRAC);
            ys[k+2] = clamp_sample(w + ((act_a[0] * ys[k+1] + act_a[1] * ys[k])
                                        >>> biquad_pkg::COEFF_FRAC));
            y[k] = ys[k+2][15:0];
        end
        fir_hist[0] = xs[NSAMP];
        fir_hist[1] = xs[NSAMP+1];
        iir_y2 = ys[NSAMP];
        iir_y1 = ys[NSAMP+1];
    endtask

    // one frame per cycle with zero frames when nothing is queued
    always @(negedge clk_i) begin : frame_stream
        frame_t cur;
        frame_t ref_out;
        if (running) begin
            if (exp_q.size() >= 2) begin
                check_value("dat_o", dat_out, exp_q.pop_front());
            end
            cur = '0;
            if (stim_q.size() > 0) begin
                cur = stim_q.pop_front();
            end
            dat_in = cur;
            model_frame(cur, ref_out);
            exp_q.push_back(ref_out);
        end
    end

    task automatic activate_model();
        act_b = stg_b;
        act_a = stg_a;
    endtask

    task automatic bus_access(input logic we, input logic [6:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        bit acked;
        @(negedge wb_clk_i);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.sel = '1;
        wb_req.dat = wdata;
        waited = 0;
        acked = 1'b0;
        while (!acked && waited < 40) begin
            @(negedge wb_clk_i);
            waited++;
            acked = wb_ack;
        end
        rdata = wb_rdata;
        // the cycle ends on the edge after ack is seen
        @(negedge wb_clk_i);
        wb_req = '0;
        if (!acked) begin
            errors++;
            $display("Timeout: no Wishbone acknowledge for address %h", adr);
        end
    endtask

    task automatic write_reg(input logic [6:0] adr, input logic [31:0] wdata);
        logic [31:0] rdata;
        bus_access(1'b1, adr, wdata, rdata);
        case (adr)
            7'h00: begin
                if (wdata[0]) begin
                    activate_model();
                end
            end
            biquad_pkg::SEL_B0: stg_b[0] = longint'($signed(wdata[17:0]));
            biquad_pkg::SEL_B1: stg_b[1] = longint'($signed(wdata[17:0]));
            biquad_pkg::SEL_B2: stg_b[2] = longint'($signed(wdata[17:0]));
            biquad_pkg::SEL_A1: stg_a[0] = longint'($signed(wdata[17:0]));
            biquad_pkg::SEL_A2: stg_a[1] = longint'($signed(wdata[17:0]));
            default: ;
        endcase
    endtask

    task automatic pulse_global_update();
        @(negedge wb_clk_i);
        global_update = 1'b1;
        @(negedge wb_clk_i);
        global_update = 1'b0;
        activate_model();
    endtask

    task automatic push_random_frames(input int n, input bit full_scale);
        frame_t f;
        logic [31:0] r;
        @(posedge clk_i);
        for (int i = 0; i < n; i++) begin
            for (int k = 0; k < NSAMP; k++) begin
                r = $random(seed);
                f[k] = full_scale ? (r[0] ? 16'h7fff : 16'h8000) : r[15:0];
            end
            stim_q.push_back(f);
        end
    endtask

    // all frames out and the model state back at zero
    task automatic wait_quiet();
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        while (quiet < QUIET_CYCLES && waited < 2000) begin
            @(posedge clk_i);
            waited++;
            if (stim_q.size() == 0 && fir_hist[0] == 0 && fir_hist[1] == 0
                && iir_y1 == 0 && iir_y2 == 0) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < QUIET_CYCLES) begin
            errors++;
            $display("Timeout: the filter did not settle to zero output");
        end
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %0d %s: %0d errors", tests_done, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic reset_passthrough();
        logic [31:0] rdata;
        @(negedge clk_i);
        check_value("dat_o after reset", dat_out, '0);
        push_random_frames(20, 1'b0);
        wait_quiet();
        bus_access(1'b0, 7'h00, 32'h0, rdata);
        check_value("read data", (NSAMP*16)'(rdata), '0);
        finish_test("reset and passthrough");
    endtask

    task automatic staged_write_idle();
        write_reg(biquad_pkg::SEL_B0, coeff_word(32768));
        push_random_frames(20, 1'b0);
        wait_quiet();
        finish_test("staging without update");
    endtask

    task automatic fir_random_frames();
        write_reg(biquad_pkg::SEL_B0, coeff_word(8192));
        write_reg(biquad_pkg::SEL_B1, coeff_word(-12288));
        write_reg(biquad_pkg::SEL_B2, coeff_word(4096));
        write_reg(7'h00, 32'h1);
        wait_quiet();
        push_random_frames(30, 1'b0);
        wait_quiet();
        finish_test("FIR response");
    endtask

    task automatic pole_impulse_and_noise();
        frame_t impulse;
        write_reg(biquad_pkg::SEL_A1, coeff_word(-8192));
        write_reg(biquad_pkg::SEL_A2, coeff_word(-4096));
        pulse_global_update();
        wait_quiet();
        impulse = '0;
        impulse[0] = 16'd12000;
        @(posedge clk_i);
        stim_q.push_back(impulse);
        wait_quiet();
        push_random_frames(30, 1'b0);
        wait_quiet();
        finish_test("pole response");
    endtask

    task automatic full_scale_clamp();
        write_reg(biquad_pkg::SEL_B0, coeff_word(131071));
        write_reg(biquad_pkg::SEL_B1, coeff_word(-131072));
        write_reg(biquad_pkg::SEL_B2, coeff_word(0));
        write_reg(biquad_pkg::SEL_A1, coeff_word(0));
        write_reg(biquad_pkg::SEL_A2, coeff_word(0));
        write_reg(7'h00, 32'h1);
        wait_quiet();
        push_random_frames(20, 1'b1);
        wait_quiet();
        finish_test("saturation");
    endtask

    task automatic unmapped_write_ignored();
        write_reg(7'h20, 32'h0001_2345);
        write_reg(7'h00, 32'h1);
        wait_quiet();
        push_random_frames(20, 1'b0);
        wait_quiet();
        finish_test("unmapped write");
    endtask

    initial begin
        arst_n_i = 1'b0;
        wb_req = '0;
        global_update = 1'b0;
        dat_in = '0;
        stg_b = '{16384, 0, 0};
        act_b = '{16384, 0, 0};
        stg_a = '{0, 0};
        act_a = '{0, 0};
        fir_hist = '{0, 0};
        iir_y1 = 0;
        iir_y2 = 0;
        repeat (16) @(negedge clk_i);
        arst_n_i = 1'b1;
        // the two frames in flight right after reset are zero
        exp_q.push_back('0);
        exp_q.push_back('0);
        @(posedge clk_i);
        running = 1'b1;
        reset_passthrough();
        staged_write_idle();
        fir_random_frames();
        pole_impulse_and_noise();
        full_scale_clamp();
        unmapped_write_ignored();
        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
